// ==== compile.f ====
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_div.sv
verilog/ex_mext.sv
verilog/ex_mem_reg.sv
verilog/ex_stage.sv
tests/ex_stage_props.sv
tests/ex_stage_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module ex_stage_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module ex_stage_tb \
		-Mdir obj_dir -o ex_stage_sim
	-./obj_dir/ex_stage_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/ex_stage_tb.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_stage_tb
  import ex_pkg::*;
();

  // ALU, control and M groups, six divide corner cases, three credit-test instructions
  localparam int NUM_INSTR = 249;
  localparam int LIMIT     = 40 * NUM_INSTR + 500;

  // One expected result per accepted instruction
  typedef struct {
    reg_addr_t rd;
    xlen_t     res;
    logic      wr;
    logic      trap;
    logic      redir;
    xlen_t     tgt;
    logic      is_div;
    int        acc_cycle;
  } exp_t;

  logic      clk;
  logic      rst_n = 1'b0;
  logic      in_valid = 1'b0;
  op_class_t in_class = OP_REG;
  funct3_t   in_funct3 = '0;
  logic      in_funct7_b5 = 1'b0;
  reg_addr_t in_rd = '0;
  xlen_t     in_rs1_data = '0;
  xlen_t     in_rs2_data = '0;
  xlen_t     in_imm = '0;
  xlen_t     in_pc = '0;
  logic      busy;
  logic      out_valid;
  reg_addr_t out_rd;
  logic      out_reg_write;
  xlen_t     out_result;
  logic      out_trap;
  logic      out_redirect;
  xlen_t     out_target;
  logic      credit_return = 1'b0;

  logic [31:0] stim_seed = 32'hb7e035de;
  logic [31:0] mem_seed = 32'hb7e035de;
  exp_t        exp_q[$];
  int          ret_q[$];
  int          cycle = 0;
  int          results_seen = 0;
  logic        div_wait = 1'b0;
  logic        hold_credits = 1'b0;

  ex_stage ex_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg(inout logic [31:0] s);
    s = s * 32'd1664525 + 32'd1013904223;
    return s;
  endfunction

  task automatic report_value(string what, logic [31:0] got, logic [31:0] exp);
    $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compare_word(xlen_t got, xlen_t exp, string what);
    if (got !== exp) report_value(what, got, exp);
  endtask

  task automatic compare_index(reg_addr_t got, reg_addr_t exp, string what);
    if (got !== exp) report_value(what, 32'(got), 32'(exp));
  endtask

  task automatic compare_flag(logic got, logic exp, string what);
    if (got !== exp) report_value(what, 32'(got), 32'(exp));
  endtask

  // RV32M divide group with the zero divisor and overflow cases
  function automatic xlen_t div_model(funct3_t f3, xlen_t a, xlen_t b);
    logic  ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff) && !f3[0];
    if (b == '0) return f3[1] ? a : 32'hffff_ffff;
    if (ovf) return f3[1] ? 32'h0 : a;
    case (f3[1:0])
      2'b00:   return xlen_t'($signed(a) / $signed(b));
      2'b01:   return a / b;
      2'b10:   return xlen_t'($signed(a) % $signed(b));
      default: return a % b;
    endcase
  endfunction

  function automatic exp_t predict(op_class_t c, funct3_t f3, logic f7, reg_addr_t rd,
                                   xlen_t a, xlen_t b, xlen_t imm, xlen_t pc);
    exp_t  e;
    xlen_t ob;
    logic  take;
    logic  cond;
    e = '{default: '0};
    take = 1'b0;
    ob = (c == OP_REG) ? b : imm;
    e.rd = rd;
    e.tgt = pc + imm;
    case (c)
      OP_REG, OP_IMM: begin
        case (f3)
          3'd0: e.res = (c == OP_REG && f7) ? a - ob : a + ob;
          3'd1: e.res = a << ob[4:0];
          3'd2: e.res = {31'b0, $signed(a) < $signed(ob)};
          3'd3: e.res = {31'b0, a < ob};
          3'd4: e.res = a ^ ob;
          3'd5: e.res = f7 ? xlen_t'($signed(a) >>> ob[4:0]) : a >> ob[4:0];
          3'd6: e.res = a | ob;
          default: e.res = a & ob;
        endcase
      end
      OP_LUI:   e.res = imm;
      OP_AUIPC: e.res = pc + imm;
      OP_JAL: begin
        e.res = pc + 32'd4;
        take = 1'b1;
      end
      OP_JALR: begin
        e.res = pc + 32'd4;
        e.tgt = (a + imm) & ~32'd1;
        take = 1'b1;
      end
      OP_BRANCH: begin
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          default: cond = a >= b;
        endcase
        take = cond;
      end
      default: begin
        e.is_div = f3[2];
        e.res = f3[2] ? div_model(f3, a, b) : a * b;
      end
    endcase
    e.trap = take && (e.tgt[1:0] != 2'b00);
    e.redir = take && !e.trap;
    e.wr = (c != OP_BRANCH) && (rd != '0) && !e.trap;
    return e;
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  // Monitor and reference model, sampled at the rising edge
  always @(posedge clk) begin
    exp_t e;
    int   due;
    if (rst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) report_error("result appeared with no instruction pending");
        e = exp_q.pop_front();
        results_seen++;
        if (!e.is_div && cycle != e.acc_cycle + 1)
          report_error("result not one cycle after accept");
        if (e.is_div && cycle < e.acc_cycle + `DIV_CYCLES + 1)
          report_error("divide result arrived too early");
        if (e.is_div) div_wait = 1'b0;
        compare_flag(out_reg_write, e.wr, "reg_write");
        compare_flag(out_trap, e.trap, "trap");
        compare_flag(out_redirect, e.redir, "redirect");
        if (e.wr) begin
          compare_index(out_rd, e.rd, "rd");
          compare_word(out_result, e.res, "result");
        end
        if (e.redir) compare_word(out_target, e.tgt, "target");
        // MEM frees the slot a few cycles later
        due = cycle + 1 + int'(lcg(mem_seed) % 32'd4);
        if (ret_q.size() > 0 && due <= ret_q[$]) due = ret_q[$] + 1;
        ret_q.push_back(due);
      end else if (div_wait && !busy) begin
        report_error("busy dropped while a divide was running");
      end
      if (in_valid && !busy) begin
        e = predict(in_class, in_funct3, in_funct7_b5, in_rd, in_rs1_data, in_rs2_data,
                    in_imm, in_pc);
        e.acc_cycle = cycle;
        if (e.is_div) div_wait = 1'b1;
        exp_q.push_back(e);
      end
    end
  end

  // MEM model returning one credit per pulse
  always @(posedge clk) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else if (!hold_credits && ret_q.size() > 0 && ret_q[0] <= cycle) begin
      void'(ret_q.pop_front());
      credit_return <= 1'b1;
    end else begin
      credit_return <= 1'b0;
    end
  end

  task automatic present(op_class_t c, funct3_t f3, logic f7, reg_addr_t rd,
                         xlen_t a, xlen_t b, xlen_t imm, xlen_t pc);
    in_valid     <= 1'b1;
    in_class     <= c;
    in_funct3    <= f3;
    in_funct7_b5 <= f7;
    in_rd        <= rd;
    in_rs1_data  <= a;
    in_rs2_data  <= b;
    in_imm       <= imm;
    in_pc        <= pc;
  endtask

  // Hold the instruction until an edge with busy low takes it
  task automatic wait_accept();
    do @(posedge clk); while (busy);
  endtask

  task automatic rand_alu(logic wait_acc);
    logic [31:0] r;
    op_class_t   c;
    xlen_t       imm;
    r = lcg(stim_seed);
    c = op_class_t'({1'b0, r[1:0]});
    imm = {{20{r[31]}}, r[31:20]};
    // Immediate shifts carry funct7 bit 5 in imm bit 10
    if (c == OP_IMM && r[4:2] == 3'd5) imm = {21'b0, r[5], 5'b0, r[24:20]};
    if (c == OP_LUI || c == OP_AUIPC) imm = {r[31:12], 12'b0};
    present(c, r[4:2], r[5], r[10:6], lcg(stim_seed), lcg(stim_seed), imm,
            {lcg(stim_seed) & 32'hffff_fffc});
    if (wait_acc) wait_accept();
  endtask

  task automatic rand_ctl();
    logic [31:0] r;
    op_class_t   c;
    funct3_t     f3;
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm;
    r = lcg(stim_seed);
    c = (r[1:0] == 2'd0) ? OP_JAL : (r[1:0] == 2'd1) ? OP_JALR : OP_BRANCH;
    case (r[4:2] % 3'd6)
      3'd0: f3 = 3'd0;
      3'd1: f3 = 3'd1;
      3'd2: f3 = 3'd4;
      3'd3: f3 = 3'd5;
      3'd4: f3 = 3'd6;
      default: f3 = 3'd7;
    endcase
    a = lcg(stim_seed);
    b = r[5] ? a : lcg(stim_seed);
    if (!r[6]) a = a & 32'hffff_fffc;
    // One target in four is misaligned by two
    imm = {{19{r[31]}}, r[31:20], 1'b0} & 32'hffff_fffc;
    if (r[8:7] == 2'd0) imm = imm | 32'd2;
    present(c, (c == OP_BRANCH) ? f3 : 3'd0, 1'b0, r[13:9], a, b, imm,
            {lcg(stim_seed) & 32'hffff_fffc});
    wait_accept();
  endtask

  task automatic rand_mext();
    logic [31:0] r;
    funct3_t     f3;
    xlen_t       b;
    r = lcg(stim_seed);
    case (r % 32'd5)
      32'd0: f3 = 3'd0;
      32'd1: f3 = 3'd4;
      32'd2: f3 = 3'd5;
      32'd3: f3 = 3'd6;
      default: f3 = 3'd7;
    endcase
    b = (r[9:8] == 2'd0) ? {28'b0, r[13:10]} : lcg(stim_seed);
    present(OP_MEXT, f3, 1'b0, r[20:16], lcg(stim_seed), b, '0, '0);
    wait_accept();
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    // Let the last accepted instruction reach the model queue
    @(posedge clk);
    while (exp_q.size() > 0 || ret_q.size() > 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int base;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    repeat (120) rand_alu(1'b1);
    repeat (80) rand_ctl();
    repeat (40) rand_mext();
    // Zero divisor and signed overflow for each divide kind
    for (int k = 4; k < 8; k++) begin
      present(OP_MEXT, funct3_t'(k), 1'b0, 5'd7, 32'h1234_5678, 32'h0, '0, '0);
      wait_accept();
    end
    present(OP_MEXT, 3'd4, 1'b0, 5'd8, 32'h8000_0000, 32'hffff_ffff, '0, '0);
    wait_accept();
    present(OP_MEXT, 3'd6, 1'b0, 5'd9, 32'h8000_0000, 32'hffff_ffff, '0, '0);
    wait_accept();
    drain();
    // Withhold credits, so the third instruction must wait
    hold_credits <= 1'b1;
    base = results_seen;
    rand_alu(1'b1);
    rand_alu(1'b1);
    rand_alu(1'b0);
    repeat (8) begin
      @(posedge clk);
      if (!busy) report_error("busy low with no credits left");
    end
    if (results_seen - base != `EX_CREDITS) report_error("wrong result count without credits");
    hold_credits <= 1'b0;
    wait_accept();
    drain();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== tests/ex_stage_props.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_stage_props
  import ex_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input credit_t credits,
  input logic    credit_return,
  input logic    accept,
  input logic    out_valid,
  input logic    busy
);

  // MEM never grants more slots than it has
  credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= credit_t'(`EX_CREDITS))
    else $error("credit count above limit");

  // With no slot left and none coming back, nothing is taken
  accept_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (credits == '0) && !credit_return |=> credits == '0)
    else $error("instruction accepted with no credit");

  // A result stays valid for one cycle unless a new accept follows it
  valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !accept |=> !out_valid)
    else $error("out_valid held longer than one cycle");

  // Stage is ready right after reset
  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !busy)
    else $error("busy high after reset");

endmodule

bind ex_mem_reg ex_stage_props props_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .credits      (credits),
  .credit_return(credit_return),
  .accept       (accept),
  .out_valid    (out_valid),
  .busy         (busy)
);

// ==== verilog/ex_stage.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  op_class_t in_class,
  input  funct3_t   in_funct3,
  input  logic      in_funct7_b5,
  input  reg_addr_t in_rd,
  input  xlen_t     in_rs1_data,
  input  xlen_t     in_rs2_data,
  input  xlen_t     in_imm,
  input  xlen_t     in_pc,
  output logic      busy,
  output logic      out_valid,
  output reg_addr_t out_rd,
  output logic      out_reg_write,
  output xlen_t     out_result,
  output logic      out_trap,
  output logic      out_redirect,
  output xlen_t     out_target,
  input  logic      credit_return
);

  xlen_t alu_result;
  xlen_t link;
  xlen_t target;
  logic  take;
  logic  misalign;
  xlen_t m_result;
  logic  m_done;
  logic  mext_busy;
  logic  accept;
  logic  mext_start;

  // Every accepted M instruction starts the M unit
  assign mext_start = accept && (in_class == OP_MEXT);

  ex_alu alu_inst (
    .op_class  (in_class),
    .funct3    (in_funct3),
    .funct7_b5 (in_funct7_b5),
    .rs1_data  (in_rs1_data),
    .rs2_data  (in_rs2_data),
    .imm       (in_imm),
    .pc        (in_pc),
    .alu_result(alu_result)
  );

  ex_branch branch_inst (
    .op_class(in_class),
    .funct3  (in_funct3),
    .rs1_data(in_rs1_data),
    .imm     (in_imm),
    .pc      (in_pc),
    .rs2_data(in_rs2_data),
    .link    (link),
    .target  (target),
    .take    (take),
    .misalign(misalign)
  );

  ex_mext mext_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (mext_start),
    .funct3  (in_funct3),
    .rs1_data(in_rs1_data),
    .rs2_data(in_rs2_data),
    .m_result(m_result),
    .m_done  (m_done),
    .busy    (mext_busy)
  );

  ex_mem_reg mem_reg_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .op_class     (in_class),
    .funct3       (in_funct3),
    .rd           (in_rd),
    .alu_result   (alu_result),
    .imm          (in_imm),
    .link         (link),
    .take         (take),
    .target       (target),
    .misalign     (misalign),
    .m_result     (m_result),
    .m_done       (m_done),
    .mext_busy    (mext_busy),
    .credit_return(credit_return),
    .accept       (accept),
    .busy         (busy),
    .out_valid    (out_valid),
    .out_rd       (out_rd),
    .out_reg_write(out_reg_write),
    .out_result   (out_result),
    .out_trap     (out_trap),
    .out_redirect (out_redirect),
    .out_target   (out_target)
  );

endmodule

// ==== verilog/ex_mem_reg.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_mem_reg
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  op_class_t op_class,
  input  funct3_t   funct3,
  input  reg_addr_t rd,
  input  xlen_t     alu_result,
  input  xlen_t     imm,
  input  xlen_t     link,
  input  logic      take,
  input  xlen_t     target,
  input  logic      misalign,
  input  xlen_t     m_result,
  input  logic      m_done,
  input  logic      mext_busy,
  input  logic      credit_return,
  output logic      accept,
  output logic      busy,
  output logic      out_valid,
  output reg_addr_t out_rd,
  output logic      out_reg_write,
  output xlen_t     out_result,
  output logic      out_trap,
  output logic      out_redirect,
  output xlen_t     out_target
);

  credit_t   credits;
  logic      is_div;
  logic      div_pend;
  reg_addr_t pend_rd;
  xlen_t     sel_result;

  // No slot in MEM or divider occupied holds ID
  assign busy   = mext_busy || (credits == '0);
  assign accept = in_valid && !busy;

  assign is_div = (op_class == OP_MEXT) && funct3[2];

  // One credit per accepted instruction, one back per freed slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= credit_t'(`EX_CREDITS);
    end else begin
      case ({accept, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Writeback value by class
  always_comb begin
    case (op_class)
      OP_LUI:          sel_result = imm;
      OP_JAL, OP_JALR: sel_result = link;
      OP_MEXT:         sel_result = m_result;
      OP_BRANCH:       sel_result = '0;
      default:         sel_result = alu_result;
    endcase
  end

  // Output register, divides complete later on m_done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_pend      <= 1'b0;
      out_valid     <= 1'b0;
      out_reg_write <= 1'b0;
      out_trap      <= 1'b0;
      out_redirect  <= 1'b0;
    end else if (accept && is_div) begin
      div_pend  <= 1'b1;
      out_valid <= 1'b0;
      out_reg_write <= 1'b0;
      out_trap      <= 1'b0;
      out_redirect  <= 1'b0;
    end else if (accept) begin
      out_valid     <= 1'b1;
      // Trapped jumps and branches never write
      out_reg_write <= (op_class != OP_BRANCH) && (rd != '0) && !misalign;
      out_trap      <= misalign;
      out_redirect  <= take && !misalign;
    end else if (m_done && div_pend) begin
      div_pend      <= 1'b0;
      out_valid     <= 1'b1;
      out_reg_write <= (pend_rd != '0);
      out_trap      <= 1'b0;
      out_redirect  <= 1'b0;
    end else begin
      out_valid     <= 1'b0;
      out_reg_write <= 1'b0;
      out_trap      <= 1'b0;
      out_redirect  <= 1'b0;
    end
  end

  // Payload of the result
  always_ff @(posedge clk) begin
    if (accept && is_div) begin
      pend_rd <= rd;
    end else if (accept) begin
      out_rd     <= rd;
      out_result <= sel_result;
      out_target <= target;
    end else if (m_done && div_pend) begin
      out_rd     <= pend_rd;
      out_result <= m_result;
    end
  end

endmodule

// ==== verilog/ex_mext.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_mext
  import ex_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start,
  input  funct3_t funct3,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  output xlen_t   m_result,
  output logic    m_done,
  output logic    busy
);

  mc_state_t mc_state;
  logic      div_start;
  logic      div_done;
  xlen_t     div_result;
  xlen_t     product;

  // Low word of the product is sign independent
  assign product = xlen_t'(rs1_data * rs2_data);

  // Divide group has funct3 bit 2 set
  assign div_start = start && funct3[2] && (mc_state == MC_IDLE);

  // Stay in EXEC until the divider reports its result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mc_state <= MC_IDLE;
    end else begin
      case (mc_state)
        MC_IDLE: if (div_start) mc_state <= MC_EXEC;
        MC_EXEC: if (div_done) mc_state <= MC_IDLE;
        default: mc_state <= MC_IDLE;
      endcase
    end
  end

  assign busy   = (mc_state == MC_EXEC);
  assign m_done = div_done;

  // ID may already present the next instruction, so select by state
  assign m_result = busy ? div_result : product;

  // DIV and REM are signed, DIVU and REMU are not
  ex_div div_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .is_signed(!funct3[0]),
    .want_rem (funct3[1]),
    .dividend (rs1_data),
    .divisor  (rs2_data),
    .done     (div_done),
    .result   (div_result)
  );

endmodule

// ==== verilog/ex_div.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_div
  import ex_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  logic  is_signed,
  input  logic  want_rem,
  input  xlen_t dividend,
  input  xlen_t divisor,
  output logic  done,
  output xlen_t result
);

  div_state_t                    state;
  logic [$clog2(`DIV_CYCLES)-1:0] step;
  xlen_t                         quo;
  xlen_t                         rem;
  xlen_t                         divs;
  xlen_t                         dvd_orig;
  logic                          neg_q;
  logic                          neg_r;
  logic                          by_zero;
  logic                          ovf;
  logic                          rem_sel;
  logic [`XLEN:0]                rem_shift;
  logic [`XLEN:0]                trial;

  // Next partial remainder with the next dividend bit shifted in
  assign rem_shift = {rem, quo[`XLEN-1]};
  assign trial     = rem_shift - {1'b0, divs};

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            step  <= '0;
          end
        end
        RUN: begin
          step <= step + 1'b1;
          if (step == ($clog2(`DIV_CYCLES))'(`DIV_CYCLES - 1)) state <= DONE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operands as magnitudes, signs and special cases kept aside
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      quo      <= (is_signed && dividend[`XLEN-1]) ? -dividend : dividend;
      divs     <= (is_signed && divisor[`XLEN-1]) ? -divisor : divisor;
      rem      <= '0;
      dvd_orig <= dividend;
      neg_q    <= is_signed && (dividend[`XLEN-1] ^ divisor[`XLEN-1]);
      neg_r    <= is_signed && dividend[`XLEN-1];
      by_zero  <= (divisor == '0);
      ovf      <= is_signed && (dividend == {1'b1, {(`XLEN-1){1'b0}}}) && (divisor == '1);
      rem_sel  <= want_rem;
    end else if (state == RUN) begin
      // Restoring step, keep the difference only when it is not negative
      if (!trial[`XLEN]) begin
        rem <= trial[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_shift[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b0};
      end
    end
  end

  assign done = (state == DONE);

  // Sign fix and RISC-V special cases
  always_comb begin
    if (by_zero) begin
      result = rem_sel ? dvd_orig : '1;
    end else if (ovf) begin
      result = rem_sel ? '0 : dvd_orig;
    end else if (rem_sel) begin
      result = neg_r ? -rem : rem;
    end else begin
      result = neg_q ? -quo : quo;
    end
  end

endmodule

// ==== verilog/ex_branch.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_branch
  import ex_pkg::*;
(
  input  op_class_t op_class,
  input  funct3_t   funct3,
  input  xlen_t     rs1_data,
  input  xlen_t     imm,
  input  xlen_t     pc,
  input  xlen_t     rs2_data,
  output xlen_t     link,
  output xlen_t     target,
  output logic      take,
  output logic      misalign
);

  logic  cond;
  logic  is_eq;
  logic  is_lt;
  logic  is_ltu;
  xlen_t pc_rel;
  xlen_t reg_ind;

  // Shared comparator results
  assign is_eq  = (rs1_data == rs2_data);
  assign is_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign is_ltu = (rs1_data < rs2_data);

  // Branch condition by funct3
  always_comb begin
    case (funct3)
      3'b000:  cond = is_eq;
      3'b001:  cond = !is_eq;
      3'b100:  cond = is_lt;
      3'b101:  cond = !is_lt;
      3'b110:  cond = is_ltu;
      3'b111:  cond = !is_ltu;
      // Reserved encodings never branch
      default: cond = 1'b0;
    endcase
  end

  // Dedicated adders for both target forms
  assign pc_rel  = pc + imm;
  assign reg_ind = rs1_data + imm;

  // JALR clears bit 0 of its target
  assign target = (op_class == OP_JALR) ? {reg_ind[`XLEN-1:1], 1'b0} : pc_rel;

  // Return address of JAL and JALR
  assign link = pc + xlen_t'(4);

  // Any jump or a taken branch changes the flow
  always_comb begin
    case (op_class)
      OP_BRANCH:        take = cond;
      OP_JAL, OP_JALR:  take = 1'b1;
      default:          take = 1'b0;
    endcase
  end

  // Targets must be word aligned without the C extension
  assign misalign = take && (|target[1:0]);

endmodule

// ==== verilog/ex_alu.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_alu
  import ex_pkg::*;
(
  input  op_class_t op_class,
  input  funct3_t   funct3,
  input  logic      funct7_b5,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data,
  input  xlen_t     imm,
  input  xlen_t     pc,
  output xlen_t     alu_result
);

  alu_op_t                    alu_op;
  xlen_t                      op_a;
  xlen_t                      op_b;
  logic [$clog2(`XLEN)-1:0]   shamt;

  // Operation decode from class and funct fields
  always_comb begin
    alu_op = ADD;
    if (op_class == OP_REG || op_class == OP_IMM) begin
      case (funct3)
        // Subtract exists only in the register form
        3'b000: alu_op = (op_class == OP_REG && funct7_b5) ? SUB : ADD;
        3'b001: alu_op = SLL;
        3'b010: alu_op = SLT;
        3'b011: alu_op = SLTU;
        3'b100: alu_op = XOR;
        // Immediate shifts carry bit 30 in imm as well
        3'b101: alu_op = funct7_b5 ? SRA : SRL;
        3'b110: alu_op = OR;
        default: alu_op = AND;
      endcase
    end
  end

  // Operand A is pc for AUIPC
  always_comb begin
    case (op_class)
      OP_AUIPC: op_a = pc;
      default:  op_a = rs1_data;
    endcase
  end

  // Operand B is rs2 for the register form, immediate otherwise
  always_comb begin
    case (op_class)
      OP_REG:  op_b = rs2_data;
      default: op_b = imm;
    endcase
  end

  // Shift amount from the low bits of operand B
  assign shamt = op_b[$clog2(`XLEN)-1:0];

  always_comb begin
    case (alu_op)
      SUB:    alu_result = op_a - op_b;
      SLL:    alu_result = op_a << shamt;
      SLT:    alu_result = xlen_t'($signed(op_a) < $signed(op_b));
      SLTU:   alu_result = xlen_t'(op_a < op_b);
      XOR:    alu_result = op_a ^ op_b;
      SRL:    alu_result = op_a >> shamt;
      SRA:    alu_result = xlen_t'($signed(op_a) >>> shamt);
      OR:     alu_result = op_a | op_b;
      AND:    alu_result = op_a & op_b;
      default: alu_result = op_a + op_b;
    endcase
  end

endmodule

// ==== verilog/ex_pkg.sv ====
`include "ex_cfg.svh"

package ex_pkg;

  // Data word and register index
  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Instruction funct3 field
  typedef logic [2:0] funct3_t;

  // Free result slots in MEM
  typedef logic [`CREDIT_W-1:0] credit_t;

  // Operation class as decoded by ID
  typedef enum logic [2:0] {
    OP_REG,
    OP_IMM,
    OP_LUI,
    OP_AUIPC,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_MEXT
  } op_class_t;

  // Integer ALU functions
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_t;

  // Sequential divider states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_t;

  // Multi-cycle operation controller
  typedef enum logic {
    MC_IDLE,
    MC_EXEC
  } mc_state_t;

endpackage

// ==== verilog/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Data path width of the RV32 core
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// Shift-subtract iterations of the divider
`define DIV_CYCLES 32

// Result slots that MEM grants to EX
`define EX_CREDITS 2

// Counter wide enough to hold EX_CREDITS
`define CREDIT_W 2

`endif
